//--- hw/pd_pkg.sv
// Shared constants and types for the packet decoder; referenced by scoped names from every RTL file
package pd_pkg;

	// Accepted PIDs, low nibble is the complement of the high nibble
	localparam logic [7:0] PID_IN    = 8'h69;
	localparam logic [7:0] PID_OUT   = 8'he1;
	localparam logic [7:0] PID_DATA0 = 8'hc3;
	localparam logic [7:0] PID_DATA1 = 8'h4b;

	// This device on the bus
	localparam logic [6:0] DEV_ADDR = 7'h2a;

	// First byte of a DATA0 payload
	localparam logic [7:0] CMD_INTERRUPT = 8'h00;
	localparam logic [7:0] CMD_HASH      = 8'h01;

	// Message block geometry
	localparam int PAYLOAD_BYTES = 64;
	localparam int BLOCK_BYTES   = 2 * PAYLOAD_BYTES;
	localparam int BLK_ADDR_W    = 7;

	// One received byte, read as a PID or as an address
	typedef union packed {
		struct packed {
			logic [3:0] pid_code;
			logic [3:0] pid_check;
		} pid;
		struct packed {
			logic       spare;
			logic [6:0] dev_addr;
		} addr;
	} rx_byte_u;

	typedef enum logic [2:0] {
		KIND_NONE,
		KIND_IN,
		KIND_OUT,
		KIND_DATA0,
		KIND_DATA1,
		KIND_BAD
	} pid_kind_e;

	// Decoder to controller, 13 bits
	typedef struct packed {
		logic      valid;
		logic      first;
		pid_kind_e kind;
		rx_byte_u  data;
	} rx_tok_t;

	// Controller to block buffer, 10 bits
	typedef struct packed {
		logic       en;
		logic       half;
		logic [7:0] data;
	} buf_wr_t;

endpackage

//--- hw/pid_decode.sv
// Registers strobed bytes from the SIE and tags the first byte of each packet with its PID kind
module pid_decode (
	input  logic             clk,
	input  logic             n_rst,
	input  logic [7:0]       i_rx_data,
	input  logic             i_write_enable,
	input  logic             i_eop,
	output pd_pkg::rx_tok_t  o_tok,
	output logic             o_eop
);

	pd_pkg::rx_byte_u  rx_byte;
	pd_pkg::rx_byte_u  data_q;
	pd_pkg::pid_kind_e kind_d;
	pd_pkg::pid_kind_e kind_q;
	logic              in_pkt;
	logic              valid_q;
	logic              first_q;
	logic              eop_q;

	assign rx_byte = i_rx_data;

	// Only the first byte of a packet is a PID
	always_comb begin
		kind_d = pd_pkg::KIND_NONE;
		if (!in_pkt) begin
			if (rx_byte.pid.pid_check != ~rx_byte.pid.pid_code) begin
				kind_d = pd_pkg::KIND_BAD;
			end else begin
				case (i_rx_data)
					pd_pkg::PID_IN:    kind_d = pd_pkg::KIND_IN;
					pd_pkg::PID_OUT:   kind_d = pd_pkg::KIND_OUT;
					pd_pkg::PID_DATA0: kind_d = pd_pkg::KIND_DATA0;
					pd_pkg::PID_DATA1: kind_d = pd_pkg::KIND_DATA1;
					default:           kind_d = pd_pkg::KIND_BAD;
				endcase
			end
		end
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			in_pkt  <= 1'b0;
			valid_q <= 1'b0;
			first_q <= 1'b0;
			kind_q  <= pd_pkg::KIND_NONE;
			eop_q   <= 1'b0;
		end else begin
			if (i_eop)
				in_pkt <= 1'b0;
			else if (i_write_enable)
				in_pkt <= 1'b1;
			valid_q <= i_write_enable;
			first_q <= i_write_enable && !in_pkt;
			kind_q  <= i_write_enable ? kind_d : pd_pkg::KIND_NONE;
			// Keeps end of packet behind the last byte
			eop_q   <= i_eop;
		end
	end

	always_ff @(posedge clk) begin
		if (i_write_enable)
			data_q <= rx_byte;
	end

	assign o_tok = '{valid: valid_q, first: first_q, kind: kind_q, data: data_q};
	assign o_eop = eop_q;

	// Byte spacing from the SIE must hold
	a_no_back_to_back: assert property (@(posedge clk) disable iff (!n_rst)
		o_tok.valid |=> !o_tok.valid)
		else $error("pid_decode: bytes strobed in consecutive cycles");

endmodule

//--- hw/packet_controller.sv
// Packet FSM: checks token addresses, holds the OUT grant and steers DATA payload into the block buffer
module packet_controller (
	input  logic             clk,
	input  logic             n_rst,
	input  pd_pkg::rx_tok_t  i_tok,
	input  logic             i_eop,
	input  logic             i_packet_done,
	output pd_pkg::buf_wr_t  o_wr,
	output logic             o_clear,
	output logic             o_host_ready,
	output logic             o_quit_hash,
	output logic             o_p_error
);

	typedef enum logic [3:0] {
		IDLE,
		IN_ADDR,
		IN_EOP,
		OUT_ADDR,
		OUT_EOP,
		DATA_CMD,
		PAYLOAD,
		DRAIN,
		ERROR
	} state_e;

	state_e     state;
	state_e     state_d;
	logic       grant;
	logic       set_grant;
	logic       half_q;
	logic       half_d;
	logic       addr_ok;
	logic       body_byte;
	logic       wr_en_d;
	logic       clear_d;
	logic       host_ready_d;
	logic       quit_d;
	logic       wr_en_q;
	logic       clear_q;
	logic       host_ready_q;
	logic       quit_q;
	logic [7:0] wr_data_q;

	assign addr_ok   = i_tok.data.addr.dev_addr == pd_pkg::DEV_ADDR;
	// Any byte after the PID
	assign body_byte = i_tok.valid && !i_tok.first;

	always_comb begin
		state_d      = state;
		half_d       = half_q;
		set_grant    = 1'b0;
		wr_en_d      = 1'b0;
		clear_d      = 1'b0;
		host_ready_d = 1'b0;
		quit_d       = 1'b0;
		case (state)
			IDLE: begin
				if (i_tok.valid && i_tok.first) begin
					case (i_tok.kind)
						pd_pkg::KIND_IN:    state_d = IN_ADDR;
						pd_pkg::KIND_OUT:   state_d = OUT_ADDR;
						pd_pkg::KIND_DATA0: state_d = grant ? DATA_CMD : DRAIN;
						pd_pkg::KIND_DATA1: begin
							state_d = grant ? PAYLOAD : DRAIN;
							half_d  = grant ? 1'b1 : half_q;
						end
						pd_pkg::KIND_BAD:   state_d = ERROR;
						default:            state_d = DRAIN;
					endcase
				end
			end
			IN_ADDR: begin
				if (i_eop)
					state_d = IDLE;
				else if (body_byte)
					state_d = addr_ok ? IN_EOP : DRAIN;
			end
			IN_EOP: begin
				if (i_eop) begin
					host_ready_d = 1'b1;
					state_d      = IDLE;
				end
			end
			OUT_ADDR: begin
				if (i_eop) begin
					state_d = IDLE;
				end else if (body_byte) begin
					set_grant = addr_ok;
					state_d   = addr_ok ? OUT_EOP : DRAIN;
				end
			end
			OUT_EOP: begin
				if (i_eop)
					state_d = IDLE;
			end
			DATA_CMD: begin
				if (i_eop) begin
					state_d = IDLE;
				end else if (body_byte) begin
					case (i_tok.data)
						pd_pkg::CMD_INTERRUPT: begin
							quit_d  = 1'b1;
							clear_d = 1'b1;
							state_d = DRAIN;
						end
						pd_pkg::CMD_HASH: begin
							half_d  = 1'b0;
							state_d = PAYLOAD;
						end
						default: state_d = ERROR;
					endcase
				end
			end
			PAYLOAD: begin
				// Done wins over a byte in the same cycle
				if (i_eop)
					state_d = IDLE;
				else if (i_packet_done)
					state_d = DRAIN;
				else if (body_byte)
					wr_en_d = 1'b1;
			end
			DRAIN: begin
				if (i_eop)
					state_d = IDLE;
			end
			ERROR: begin
				if (i_eop) begin
					clear_d = 1'b1;
					state_d = IDLE;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state        <= IDLE;
			grant        <= 1'b0;
			half_q       <= 1'b0;
			wr_en_q      <= 1'b0;
			clear_q      <= 1'b0;
			host_ready_q <= 1'b0;
			quit_q       <= 1'b0;
		end else begin
			state        <= state_d;
			half_q       <= half_d;
			wr_en_q      <= wr_en_d;
			clear_q      <= clear_d;
			host_ready_q <= host_ready_d;
			quit_q       <= quit_d;
			// Done may land after eop, so the grant is tracked outside the FSM
			if (set_grant)
				grant <= 1'b1;
			else if (i_packet_done && half_q)
				grant <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en_d)
			wr_data_q <= i_tok.data;
	end

	assign o_wr         = '{en: wr_en_q, half: half_q, data: wr_data_q};
	assign o_clear      = clear_q;
	assign o_host_ready = host_ready_q;
	assign o_quit_hash  = quit_q;
	assign o_p_error    = state == ERROR;

	a_wr_from_payload: assert property (@(posedge clk) disable iff (!n_rst)
		o_wr.en |-> $past(state == PAYLOAD))
		else $error("packet_controller: buffer write outside PAYLOAD");

	a_no_wr_in_error: assert property (@(posedge clk) disable iff (!n_rst)
		!(o_p_error && o_wr.en))
		else $error("packet_controller: write during protocol error");

endmodule

//--- hw/block_buffer.sv
// Two-half message block store for the hash engine; counts payload bytes and reports completion
module block_buffer (
	input  logic                          clk,
	input  logic                          n_rst,
	input  pd_pkg::buf_wr_t               i_wr,
	input  logic                          i_clear,
	input  logic [pd_pkg::BLK_ADDR_W-1:0] i_rd_addr,
	output logic [7:0]                    o_rd_data,
	output logic                          o_packet_done,
	output logic                          o_block_ready
);

	localparam int CNT_W = pd_pkg::BLK_ADDR_W - 1;

	logic [7:0]       mem [pd_pkg::BLOCK_BYTES];
	logic [CNT_W-1:0] cnt;
	logic             last_byte;
	logic             done_q;
	logic             ready_q;

	// 64th byte of the current half
	assign last_byte = i_wr.en && (cnt == CNT_W'(pd_pkg::PAYLOAD_BYTES - 1));

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			cnt     <= '0;
			done_q  <= 1'b0;
			ready_q <= 1'b0;
		end else begin
			if (i_clear)
				cnt <= '0;
			else if (i_wr.en)
				cnt <= cnt + 1'b1;
			done_q  <= last_byte;
			ready_q <= last_byte && i_wr.half;
		end
	end

	// Half bit selects the upper 64 bytes
	always_ff @(posedge clk) begin
		if (i_wr.en)
			mem[{i_wr.half, cnt}] <= i_wr.data;
	end

	assign o_rd_data     = mem[i_rd_addr];
	assign o_packet_done = done_q;
	assign o_block_ready = ready_q;

	a_clear_vs_write: assert property (@(posedge clk) disable iff (!n_rst)
		!(i_clear && i_wr.en))
		else $error("block_buffer: clear and write in the same cycle");

endmodule

//--- hw/packet_decoder.sv
// Top level of the receive path: PID decode, packet FSM and block buffer with a host read port
module packet_decoder (
	input  logic                          clk,
	input  logic                          n_rst,
	input  logic [7:0]                    i_rx_data,
	input  logic                          i_write_enable,
	input  logic                          i_eop,
	input  logic [pd_pkg::BLK_ADDR_W-1:0] i_rd_addr,
	output logic [7:0]                    o_rd_data,
	output logic                          o_host_ready,
	output logic                          o_block_ready,
	output logic                          o_quit_hash,
	output logic                          o_p_error
);

	pd_pkg::rx_tok_t tok;
	pd_pkg::buf_wr_t wr;
	logic            eop_d;
	logic            clear;
	logic            packet_done;

	pid_decode i_pid_decode (
		.clk            (clk),
		.n_rst          (n_rst),
		.i_rx_data      (i_rx_data),
		.i_write_enable (i_write_enable),
		.i_eop          (i_eop),
		.o_tok          (tok),
		.o_eop          (eop_d)
	);

	packet_controller i_packet_controller (
		.clk           (clk),
		.n_rst         (n_rst),
		.i_tok         (tok),
		.i_eop         (eop_d),
		.i_packet_done (packet_done),
		.o_wr          (wr),
		.o_clear       (clear),
		.o_host_ready  (o_host_ready),
		.o_quit_hash   (o_quit_hash),
		.o_p_error     (o_p_error)
	);

	block_buffer i_block_buffer (
		.clk           (clk),
		.n_rst         (n_rst),
		.i_wr          (wr),
		.i_clear       (clear),
		.i_rd_addr     (i_rd_addr),
		.o_rd_data     (o_rd_data),
		.o_packet_done (packet_done),
		.o_block_ready (o_block_ready)
	);

endmodule

//--- test/tb_packet_decoder.sv
// Testbench for packet_decoder; drives packets on the falling edge while assertions check the events
module tb_packet_decoder;

	// IN tests, bad PID, full block, ungranted DATA0, interrupt and restart
	localparam int TOTAL_BYTES   = 4 + 2 + 133 + 66 + 147;
	localparam int WATCHDOG_TIME = 20 * TOTAL_BYTES * 4 + 20 * 1000;

	typedef struct packed {
		logic [7:0] host;
		logic [7:0] ready;
		logic [7:0] quit;
	} event_cnt_t;

	logic                          clk;
	logic                          n_rst;
	logic [7:0]                    rx_data;
	logic                          write_enable;
	logic                          eop;
	logic [pd_pkg::BLK_ADDR_W-1:0] rd_addr;
	logic [7:0]                    rd_data;
	logic                          host_ready;
	logic                          block_ready;
	logic                          quit_hash;
	logic                          p_error;

	logic [31:0] lfsr_state;
	logic [7:0]  model [pd_pkg::BLOCK_BYTES];
	event_cnt_t  seen;
	event_cnt_t  expected;
	logic        idle_window;
	logic        err_allowed;
	logic        err_required;
	logic        count_check;
	logic        cnt_clear;
	logic        rd_check;
	logic [7:0]  exp_rd;

	packet_decoder i_packet_decoder (
		.clk            (clk),
		.n_rst          (n_rst),
		.i_rx_data      (rx_data),
		.i_write_enable (write_enable),
		.i_eop          (eop),
		.i_rd_addr      (rd_addr),
		.o_rd_data      (rd_data),
		.o_host_ready   (host_ready),
		.o_block_ready  (block_ready),
		.o_quit_hash    (quit_hash),
		.o_p_error      (p_error)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		b = '0;
		for (int i = 0; i < 8; i++) begin
			b = {b[6:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		fail_run($sformatf("error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp));
	endtask

	// Starts and ends on a falling edge
	task automatic send_byte(input logic [7:0] b);
		rx_data      = b;
		write_enable = 1'b1;
		@(negedge clk);
		write_enable = 1'b0;
		@(negedge clk);
	endtask

	task automatic send_eop();
		eop = 1'b1;
		@(negedge clk);
		eop = 1'b0;
		@(negedge clk);
		@(negedge clk);
	endtask

	task automatic send_payload(input logic half, input int n, input logic keep);
		logic [7:0] b;
		for (int i = 0; i < n; i++) begin
			rand_byte(b);
			if (keep)
				model[half * pd_pkg::PAYLOAD_BYTES + i] = b;
			send_byte(b);
		end
	endtask

	task automatic check_events(input int host, input int ready, input int quit);
		repeat (4) @(negedge clk);
		expected    = '{host: 8'(host), ready: 8'(ready), quit: 8'(quit)};
		count_check = 1'b1;
		@(negedge clk);
		count_check = 1'b0;
		cnt_clear   = 1'b1;
		@(negedge clk);
		cnt_clear   = 1'b0;
	endtask

	task automatic check_block();
		for (int a = 0; a < pd_pkg::BLOCK_BYTES; a++) begin
			rd_addr  = a[pd_pkg::BLK_ADDR_W-1:0];
			exp_rd   = model[a];
			rd_check = 1'b1;
			@(negedge clk);
		end
		rd_check = 1'b0;
	endtask

	always @(posedge clk) begin
		if (cnt_clear) begin
			seen <= '0;
		end else begin
			if (host_ready)
				seen.host <= seen.host + 1'b1;
			if (block_ready)
				seen.ready <= seen.ready + 1'b1;
			if (quit_hash)
				seen.quit <= seen.quit + 1'b1;
		end
	end

	a_idle_quiet: assert property (@(posedge clk) disable iff (!n_rst)
		idle_window |-> !(host_ready || block_ready || quit_hash || p_error))
		else fail_run("an event output went high before the first packet");

	a_err_low: assert property (@(posedge clk) disable iff (!n_rst)
		!err_allowed |-> !p_error)
		else report_mismatch("o_p_error", $sampled(p_error), 0);

	a_err_high: assert property (@(posedge clk) disable iff (!n_rst)
		err_required |-> p_error)
		else report_mismatch("o_p_error", $sampled(p_error), 1);

	a_host_count: assert property (@(posedge clk) count_check |-> seen.host == expected.host)
		else report_mismatch("o_host_ready pulses", $sampled(seen.host), $sampled(expected.host));

	a_ready_count: assert property (@(posedge clk) count_check |-> seen.ready == expected.ready)
		else report_mismatch("o_block_ready pulses", $sampled(seen.ready),
			$sampled(expected.ready));

	a_quit_count: assert property (@(posedge clk) count_check |-> seen.quit == expected.quit)
		else report_mismatch("o_quit_hash pulses", $sampled(seen.quit), $sampled(expected.quit));

	a_rd_data: assert property (@(posedge clk) rd_check |-> rd_data == exp_rd)
		else report_mismatch($sformatf("o_rd_data[%0d]", $sampled(rd_addr)),
			$sampled(rd_data), $sampled(exp_rd));

	initial begin
		#(WATCHDOG_TIME);
		fail_run("timeout: the tests did not finish within the watchdog limit");
	end

	initial begin
		n_rst        = 1'b0;
		rx_data      = '0;
		write_enable = 1'b0;
		eop          = 1'b0;
		rd_addr      = '0;
		lfsr_state   = 32'hea0b;
		idle_window  = 1'b1;
		err_allowed  = 1'b0;
		err_required = 1'b0;
		count_check  = 1'b0;
		cnt_clear    = 1'b1;
		rd_check     = 1'b0;
		exp_rd       = '0;
		expected     = '0;
		repeat (10) @(negedge clk);
		n_rst     = 1'b1;
		cnt_clear = 1'b0;
		repeat (5) @(negedge clk);
		idle_window = 1'b0;

		// Bit 7 of the address byte is ignored
		send_byte(pd_pkg::PID_IN);
		send_byte({1'b1, pd_pkg::DEV_ADDR});
		send_eop();
		while (seen.host == 0)
			@(negedge clk);
		check_events(1, 0, 0);
		send_byte(pd_pkg::PID_IN);
		send_byte({1'b0, pd_pkg::DEV_ADDR ^ 7'h01});
		send_eop();
		check_events(0, 0, 0);

		// Check nibble 5 is not the complement of 5
		err_allowed = 1'b1;
		send_byte(8'h55);
		err_required = 1'b1;
		send_byte({1'b0, pd_pkg::DEV_ADDR});
		err_required = 1'b0;
		send_eop();
		err_allowed = 1'b0;
		check_events(0, 0, 0);

		send_byte(pd_pkg::PID_OUT);
		send_byte({1'b0, pd_pkg::DEV_ADDR});
		send_eop();
		send_byte(pd_pkg::PID_DATA0);
		send_byte(pd_pkg::CMD_HASH);
		send_payload(1'b0, pd_pkg::PAYLOAD_BYTES, 1'b1);
		send_eop();
		send_byte(pd_pkg::PID_DATA1);
		send_payload(1'b1, pd_pkg::PAYLOAD_BYTES, 1'b1);
		while (seen.ready == 0)
			@(negedge clk);
		send_eop();
		check_events(0, 1, 0);
		check_block();

		// Grant was used up by the last DATA1
		send_byte(pd_pkg::PID_DATA0);
		send_byte(pd_pkg::CMD_HASH);
		send_payload(1'b0, pd_pkg::PAYLOAD_BYTES, 1'b0);
		send_eop();
		check_events(0, 0, 0);
		check_block();

		// Partial payload leaves the counter off zero
		send_byte(pd_pkg::PID_OUT);
		send_byte({1'b0, pd_pkg::DEV_ADDR});
		send_eop();
		send_byte(pd_pkg::PID_DATA0);
		send_byte(pd_pkg::CMD_HASH);
		send_payload(1'b0, 10, 1'b1);
		send_eop();
		send_byte(pd_pkg::PID_DATA0);
		send_byte(pd_pkg::CMD_INTERRUPT);
		send_eop();
		while (seen.quit == 0)
			@(negedge clk);
		check_events(0, 0, 1);
		send_byte(pd_pkg::PID_DATA0);
		send_byte(pd_pkg::CMD_HASH);
		send_payload(1'b0, pd_pkg::PAYLOAD_BYTES, 1'b1);
		send_eop();
		send_byte(pd_pkg::PID_DATA1);
		send_payload(1'b1, pd_pkg::PAYLOAD_BYTES, 1'b1);
		while (seen.ready == 0)
			@(negedge clk);
		send_eop();
		check_events(0, 1, 0);
		check_block();

		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- list.f
hw/pd_pkg.sv
hw/pid_decode.sv
hw/packet_controller.sv
hw/block_buffer.sv
hw/packet_decoder.sv
test/tb_packet_decoder.sv

//--- Bender.yml
package:
  name: packet_decoder

sources:
  - hw/pd_pkg.sv
  - hw/pid_decode.sv
  - hw/packet_controller.sv
  - hw/block_buffer.sv
  - hw/packet_decoder.sv
  - target: test
    files:
      - test/tb_packet_decoder.sv
